// ==== common/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;             // 3 block bits + 8 bit word address
    localparam int WORD_W = 8;
    localparam int DATA_W = 8;

    localparam logic [3:0] DEV_CODE = 4'b1010;

    // host side
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic              busy;
        logic              ack;             // one cycle, ends a transaction
        logic              err;
        logic [DATA_W-1:0] rdata;
    } host_rsp_t;

    // commands understood by the bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_SEND,
        CMD_RECV
    } bit_cmd_e;

    typedef struct packed {
        logic              go;
        bit_cmd_e          cmd;
        logic [DATA_W-1:0] tx_byte;
        logic              last;            // nack the received byte
    } eng_cmd_t;

    typedef struct packed {
        logic              done;
        logic              nack;
        logic [DATA_W-1:0] rx_byte;
    } eng_rsp_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_W,
        SEQ_ADDR_W,
        SEQ_DATA_W,
        SEQ_RESTART,
        SEQ_CTRL_R,
        SEQ_DATA_R,
        SEQ_STOP,
        SEQ_FINISH
    } seq_state_e;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_START,
        ENG_SHIFT,
        ENG_ACK,
        ENG_STOP
    } eng_state_e;

endpackage

`default_nettype wire

// ==== eeprom_ctrl/eeprom_sequencer.sv ====
`default_nettype none

module eeprom_sequencer (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire eeprom_pkg::host_req_t req,
    output eeprom_pkg::host_rsp_t      rsp,
    output eeprom_pkg::eng_cmd_t       eng_cmd,
    input  wire eeprom_pkg::eng_rsp_t  eng_rsp
);

    eeprom_pkg::seq_state_e state;
    eeprom_pkg::seq_state_e state_n;

    // latched request
    logic [eeprom_pkg::ADDR_W-1:0] addr_q;
    logic [eeprom_pkg::DATA_W-1:0] wdata_q;
    logic                          rd_q;

    // command to the engine
    eeprom_pkg::bit_cmd_e          cmd_q;
    eeprom_pkg::bit_cmd_e          cmd_n;
    logic [eeprom_pkg::DATA_W-1:0] tx_q;
    logic [eeprom_pkg::DATA_W-1:0] tx_n;
    logic                          last_q;
    logic                          last_n;
    logic                          go_q;
    logic                          issue;
    logic                          nack_stop;

    logic                          busy;
    logic                          ack;
    logic                          err;
    logic [eeprom_pkg::DATA_W-1:0] rdata;

    logic                          strobe;
    logic [eeprom_pkg::DATA_W-1:0] ctrl_byte;   // r/w bit left clear

    assign strobe    = req.wr | req.rd;
    assign ctrl_byte = {eeprom_pkg::DEV_CODE,
                        addr_q[eeprom_pkg::ADDR_W-1:eeprom_pkg::WORD_W], 1'b0};

    always_comb begin
        state_n   = state;
        cmd_n     = cmd_q;
        tx_n      = tx_q;
        last_n    = 1'b0;
        issue     = 1'b0;
        nack_stop = 1'b0;
        case (state)
            eeprom_pkg::SEQ_IDLE: begin
                if (strobe) begin
                    state_n = eeprom_pkg::SEQ_START;
                    cmd_n   = eeprom_pkg::CMD_START;
                    issue   = 1'b1;
                end
            end
            eeprom_pkg::SEQ_FINISH: state_n = eeprom_pkg::SEQ_IDLE;
            default: begin
                if (eng_rsp.done) begin
                    issue = 1'b1;
                    case (state)
                        eeprom_pkg::SEQ_START: begin
                            state_n = eeprom_pkg::SEQ_CTRL_W;
                            cmd_n   = eeprom_pkg::CMD_SEND;
                            tx_n    = ctrl_byte;
                        end
                        eeprom_pkg::SEQ_CTRL_W: begin
                            state_n = eeprom_pkg::SEQ_ADDR_W;
                            cmd_n   = eeprom_pkg::CMD_SEND;
                            tx_n    = addr_q[eeprom_pkg::WORD_W-1:0];
                        end
                        eeprom_pkg::SEQ_ADDR_W: begin
                            if (rd_q) begin
                                state_n = eeprom_pkg::SEQ_RESTART;
                                cmd_n   = eeprom_pkg::CMD_START;
                            end else begin
                                state_n = eeprom_pkg::SEQ_DATA_W;
                                cmd_n   = eeprom_pkg::CMD_SEND;
                                tx_n    = wdata_q;
                            end
                        end
                        eeprom_pkg::SEQ_RESTART: begin
                            state_n = eeprom_pkg::SEQ_CTRL_R;
                            cmd_n   = eeprom_pkg::CMD_SEND;
                            tx_n    = ctrl_byte | 8'h01;
                        end
                        eeprom_pkg::SEQ_CTRL_R: begin
                            state_n = eeprom_pkg::SEQ_DATA_R;
                            cmd_n   = eeprom_pkg::CMD_RECV;
                            last_n  = 1'b1;            // single byte read
                        end
                        eeprom_pkg::SEQ_STOP: begin
                            state_n = eeprom_pkg::SEQ_FINISH;
                            issue   = 1'b0;
                        end
                        default: begin                 // DATA_W, DATA_R
                            state_n = eeprom_pkg::SEQ_STOP;
                            cmd_n   = eeprom_pkg::CMD_STOP;
                        end
                    endcase
                    // refused byte ends the transfer
                    if (cmd_q == eeprom_pkg::CMD_SEND && eng_rsp.nack) begin
                        state_n   = eeprom_pkg::SEQ_STOP;
                        cmd_n     = eeprom_pkg::CMD_STOP;
                        nack_stop = 1'b1;
                    end
                end
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= eeprom_pkg::SEQ_IDLE;
            go_q  <= 1'b0;
            busy  <= 1'b0;
            ack   <= 1'b0;
            err   <= 1'b0;
            rdata <= '0;
        end else begin
            state <= state_n;
            go_q  <= issue;
            ack   <= (state == eeprom_pkg::SEQ_FINISH);
            if (state == eeprom_pkg::SEQ_IDLE && strobe) begin
                busy <= 1'b1;
                err  <= 1'b0;
            end
            if (nack_stop) begin
                err <= 1'b1;
            end
            if (state == eeprom_pkg::SEQ_FINISH) begin
                busy <= 1'b0;                          // drops with ack
                if (rd_q && !err) begin
                    rdata <= eng_rsp.rx_byte;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        cmd_q  <= cmd_n;
        tx_q   <= tx_n;
        last_q <= last_n;
        if (state == eeprom_pkg::SEQ_IDLE && strobe) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
            rd_q    <= ~req.wr;                        // wr wins
        end
    end

    always_comb begin
        rsp.busy        = busy;
        rsp.ack         = ack;
        rsp.err         = err;
        rsp.rdata       = rdata;
        eng_cmd.go      = go_q;
        eng_cmd.cmd     = cmd_q;
        eng_cmd.tx_byte = tx_q;
        eng_cmd.last    = last_q;
    end

endmodule

`default_nettype wire

// ==== eeprom_ctrl/i2c_bit_engine.sv ====
`default_nettype none

module i2c_bit_engine (
    input  wire                       CLK,
    input  wire                       RESET,
    input  wire eeprom_pkg::eng_cmd_t eng_cmd,
    output eeprom_pkg::eng_rsp_t      eng_rsp,
    output logic                      scl,
    output logic                      sda_low,
    input  wire                       sda_in
);

    eeprom_pkg::eng_state_e state;

    logic [1:0]                    phase;
    logic [2:0]                    bit_cnt;
    logic [eeprom_pkg::DATA_W-1:0] sh;          // tx and rx share this
    logic                          smp;         // line value taken in phase 1
    logic                          recv;
    logic                          last;
    logic                          bus_held;    // between START and STOP
    logic                          done;
    logic                          nack;

    // state, phase and bit counters
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= eeprom_pkg::ENG_IDLE;
            phase    <= 2'd0;
            bit_cnt  <= 3'd0;
            bus_held <= 1'b0;
            done     <= 1'b0;
            nack     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == eeprom_pkg::ENG_IDLE) begin
                if (eng_cmd.go) begin
                    phase   <= 2'd0;
                    bit_cnt <= 3'd0;
                    case (eng_cmd.cmd)
                        eeprom_pkg::CMD_START: begin
                            state    <= eeprom_pkg::ENG_START;
                            bus_held <= 1'b1;
                        end
                        eeprom_pkg::CMD_STOP: state <= eeprom_pkg::ENG_STOP;
                        default: state <= eeprom_pkg::ENG_SHIFT;
                    endcase
                end
            end else begin
                phase <= phase + 2'd1;
                // slave ack, only meaningful on a send
                if (state == eeprom_pkg::ENG_ACK && phase == 2'd1) begin
                    nack <= recv ? 1'b0 : sda_in;
                end
                if (phase == 2'd3) begin
                    if (state == eeprom_pkg::ENG_SHIFT) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= eeprom_pkg::ENG_ACK;
                        end
                    end else begin
                        state <= eeprom_pkg::ENG_IDLE;
                        done  <= 1'b1;
                        if (state == eeprom_pkg::ENG_STOP) begin
                            bus_held <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // data path, msb first
    always_ff @(posedge CLK) begin
        if (state == eeprom_pkg::ENG_IDLE) begin
            if (eng_cmd.go) begin
                recv <= (eng_cmd.cmd == eeprom_pkg::CMD_RECV);
                last <= eng_cmd.last;
                if (eng_cmd.cmd == eeprom_pkg::CMD_SEND) begin
                    sh <= eng_cmd.tx_byte;
                end
            end
        end else begin
            if (phase == 2'd1) begin
                smp <= sda_in;
            end
            if (state == eeprom_pkg::ENG_SHIFT && phase == 2'd3) begin
                sh <= {sh[eeprom_pkg::DATA_W-2:0], smp};
            end
        end
    end

    // scl high in phases 1 and 2, sda moves in phase 0
    always_comb begin
        scl     = ^phase;
        sda_low = 1'b0;
        case (state)
            eeprom_pkg::ENG_START: sda_low = phase[1];             // falls in phase 2
            eeprom_pkg::ENG_STOP: begin
                scl     = (phase != 2'd0);                         // stays up once released
                sda_low = ~phase[1];
            end
            eeprom_pkg::ENG_SHIFT: sda_low = ~recv & ~sh[eeprom_pkg::DATA_W-1];
            eeprom_pkg::ENG_ACK: sda_low = recv & ~last;
            default: scl = ~bus_held;                              // park low mid transfer
        endcase
    end

    always_comb begin
        eng_rsp.done    = done;
        eng_rsp.nack    = nack;
        eng_rsp.rx_byte = sh;
    end

endmodule

`default_nettype wire

// ==== eeprom_i2c.f ====
common/eeprom_pkg.sv
eeprom_ctrl/i2c_bit_engine.sv
eeprom_ctrl/eeprom_sequencer.sv
rtl/eeprom_i2c_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_i2c.sv

// ==== rtl/eeprom_i2c_top.sv ====
`default_nettype none

module eeprom_i2c_top (
    input  wire                        CLK,
    input  wire                        RESET,
    input  wire eeprom_pkg::host_req_t req,
    output eeprom_pkg::host_rsp_t      rsp,
    output logic                       scl,
    inout  wire                        sda
);

    eeprom_pkg::eng_cmd_t eng_cmd;
    eeprom_pkg::eng_rsp_t eng_rsp;
    logic                 sda_low;
    wire                  sda_in;

    // open drain, the pullup sits on the board
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_sequencer u_sequencer (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .rsp     (rsp),
        .eng_cmd (eng_cmd),
        .eng_rsp (eng_rsp)
    );

    i2c_bit_engine u_bit_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .eng_cmd (eng_cmd),
        .eng_rsp (eng_rsp),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

`default_nettype wire

// ==== tests/eeprom_model.sv ====
`default_nettype none

module eeprom_model (
    input  wire scl,
    inout  wire sda,
    output int  stops,
    output int  faults
);

    timeunit 1ns;
    timeprecision 1ns;

    localparam time WRITE_CYCLE = 20_000;       // 20 us internal programming

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_WORD,
        M_DATA,
        M_READ
    } mstate_e;

    logic [7:0]  mem [2048];
    mstate_e     st = M_IDLE;
    logic [7:0]  sh = '0;
    logic [7:0]  dout = '0;
    logic [10:0] ptr = '0;
    int          bitcnt = 0;                    // rising scl edges in this byte
    logic        drive_low = 1'b0;
    logic        wrote = 1'b0;
    time         busy_until = 0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial begin
        stops  = 0;
        faults = 0;
    end

    // start, also repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (bitcnt > 1) faults++;           // inside a byte
            st        = M_CTRL;
            bitcnt    = 0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            if (bitcnt > 1) faults++;
            stops++;
            if (wrote) busy_until = $time + WRITE_CYCLE;
            wrote  = 1'b0;
            st     = M_IDLE;
            bitcnt = 0;
        end
    end

    always @(posedge scl) begin
        if (bitcnt == 8) begin
            bitcnt = 0;                         // ninth clock
            if (st == M_READ && sda === 1'b1) st = M_IDLE;
        end else if (st != M_IDLE) begin
            sh     = {sh[6:0], sda === 1'b1};
            bitcnt = bitcnt + 1;
        end
    end

    // slave output changes only while scl is low
    always @(negedge scl) begin
        drive_low = 1'b0;
        if (bitcnt == 8) begin
            case (st)
                M_CTRL: begin
                    if (sh[7:4] == eeprom_pkg::DEV_CODE && $time >= busy_until) begin
                        drive_low = 1'b1;
                        ptr[10:8] = sh[3:1];    // block bits
                        if (sh[0]) begin
                            st   = M_READ;
                            dout = mem[ptr];
                        end else begin
                            st = M_WORD;
                        end
                    end else begin
                        st = M_IDLE;            // no ack
                    end
                end
                M_WORD: begin
                    drive_low = 1'b1;
                    ptr[7:0]  = sh;
                    st        = M_DATA;
                end
                M_DATA: begin
                    drive_low = 1'b1;
                    mem[ptr]  = sh;
                    wrote     = 1'b1;
                    st        = M_IDLE;         // single byte writes only
                end
                default: ;                      // master answers the read byte
            endcase
        end else if (st == M_READ) begin
            drive_low = ~dout[7 - bitcnt];
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_eeprom_i2c.sv ====
`default_nettype none

module tb_eeprom_i2c;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int          HALF_PERIOD   = 50;
    localparam int          RESET_CYCLES  = 16;
    localparam int          SETTLE_CYCLES = 250;        // past the 20 us write cycle
    localparam int          WATCHDOG_NS   = 40 * 200_000;
    localparam logic [31:0] RAND_SEED     = 32'h835a23eb;

    logic                  CLK = 1'b0;
    logic                  RESET;
    eeprom_pkg::host_req_t req;
    eeprom_pkg::host_rsp_t rsp;
    wire                   scl;
    wire                   sda;
    int                    model_stops;
    int                    model_faults;

    logic [7:0]  mirror [2048];
    logic        in_txn;
    logic        txn_wr;
    logic [10:0] txn_addr;
    logic [7:0]  txn_wdata;
    int          stop_base;
    logic        chk_data;
    logic [7:0]  exp_data;
    logic        exp_err;
    int          exp_falls;
    int          data_errs = 0;
    int          proto_errs = 0;

    logic        scl_q;
    logic        sda_q;
    int          bus_falls;
    int          bus_rises;

    logic [7:0]  word;
    logic [10:0] rnd_addr [4];
    logic [10:0] addr_a;
    logic [10:0] addr_b;

    pullup (sda);                                       // bus resistor

    eeprom_i2c_top u_eeprom_i2c_top (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .rsp   (rsp),
        .scl   (scl),
        .sda   (sda)
    );

    eeprom_model u_eeprom (
        .scl    (scl),
        .sda    (sda),
        .stops  (model_stops),
        .faults (model_faults)
    );

    always #HALF_PERIOD CLK = ~CLK;

    // accepted transactions and the write mirror
    always @(posedge CLK) begin
        if (RESET) begin
            in_txn    <= 1'b0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bus_falls <= 0;
            bus_rises <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            // falling sda under high scl counts as a start and rising as a stop
            if (scl && scl_q && sda != sda_q) begin
                if (sda) begin
                    bus_rises <= bus_rises + 1;
                end else begin
                    bus_falls <= bus_falls + 1;
                end
            end
            if (rsp.ack) begin
                in_txn <= 1'b0;
                if (txn_wr && !rsp.err) mirror[txn_addr] <= txn_wdata;
            end
            if ((req.wr || req.rd) && !rsp.busy) begin
                in_txn    <= 1'b1;
                txn_wr    <= req.wr;
                txn_addr  <= req.addr;
                txn_wdata <= req.wdata;
                stop_base <= model_stops;
                bus_falls <= 0;
                bus_rises <= 0;
            end
        end
    end

    reset_quiet: assert property (@(posedge CLK)
        ((RESET && $past(RESET)) || $fell(RESET)) |-> !rsp.busy && !rsp.ack && scl && sda)
        else begin
            proto_errs++;
            $display("FAILED %0t: outputs not idle around reset", $time);
        end

    err_flag: assert property (@(posedge CLK) disable iff (RESET) rsp.ack |-> rsp.err == exp_err)
        else begin
            data_errs++;
            $display("FAILED %0t: err %b, expected %b", $time, $sampled(rsp.err),
                     $sampled(exp_err));
        end

    read_data: assert property (@(posedge CLK) disable iff (RESET)
        rsp.ack && chk_data |-> rsp.rdata == exp_data)
        else begin
            data_errs++;
            $display("FAILED %0t: read 0x%02h, expected 0x%02h", $time, $sampled(rsp.rdata),
                     $sampled(exp_data));
        end

    sda_while_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && sda != $past(sda) |-> rsp.busy)
        else begin
            proto_errs++;
            $display("FAILED %0t: sda moved under high scl outside a transaction", $time);
        end

    start_stop_only: assert property (@(posedge CLK) disable iff (RESET)
        rsp.ack |-> bus_falls == exp_falls && bus_rises == 1)
        else begin
            proto_errs++;
            $display("FAILED %0t: %0d starts and %0d stops on the bus, expected %0d and 1",
                     $time, $sampled(bus_falls), $sampled(bus_rises), $sampled(exp_falls));
        end

    assert property (@(posedge CLK) disable iff (RESET) model_faults == 0)
        else begin
            proto_errs++;
            $display("FAILED %0t: start or stop inside a byte", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET) !rsp.busy |-> scl)
        else begin
            proto_errs++;
            $display("FAILED %0t: scl low while idle", $time);
        end

    one_stop: assert property (@(posedge CLK) disable iff (RESET)
        rsp.ack |-> in_txn && model_stops - stop_base == 1)
        else begin
            proto_errs++;
            $display("FAILED %0t: ack without one stop in its own transaction", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET) rsp.ack |-> !rsp.busy && $past(rsp.busy))
        else begin
            proto_errs++;
            $display("FAILED %0t: ack not on busy falling", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET) rsp.ack |=> !rsp.ack)
        else begin
            proto_errs++;
            $display("FAILED %0t: ack longer than one cycle", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET) $fell(rsp.busy) |-> rsp.ack)
        else begin
            proto_errs++;
            $display("FAILED %0t: busy fell without ack", $time);
        end

    assert property (@(posedge CLK) disable iff (RESET)
        (req.wr || req.rd) && !rsp.busy |=> rsp.busy)
        else begin
            proto_errs++;
            $display("FAILED %0t: busy missing after strobe", $time);
        end

    task automatic start_txn(input logic wr, input logic [10:0] addr, input logic [7:0] data,
                             input logic check_rd, input logic err);
        @(posedge CLK);
        req.wr    <= wr;
        req.rd    <= ~wr;
        req.addr  <= addr;
        req.wdata <= data;
        chk_data  <= check_rd;
        exp_data  <= mirror[addr];
        exp_err   <= err;
        exp_falls <= (wr || err) ? 1 : 2;               // repeated start only on a full read
        @(posedge CLK);
        req.wr <= 1'b0;
        req.rd <= 1'b0;
    endtask

    task automatic wait_ack;
        while (!rsp.ack) @(posedge CLK);
    endtask

    task automatic write_byte(input logic [10:0] addr, input logic [7:0] data);
        start_txn(1'b1, addr, data, 1'b0, 1'b0);
        wait_ack();
    endtask

    task automatic read_check(input logic [10:0] addr, input logic err);
        start_txn(1'b0, addr, 8'h00, ~err, err);
        wait_ack();
    endtask

    task automatic settle;
        repeat (SETTLE_CYCLES) @(posedge CLK);
    endtask

    // second write strobe lands mid transaction
    task automatic write_with_busy_strobe(input logic [10:0] addr, input logic [7:0] data,
                                          input logic [10:0] other, input logic [7:0] odata);
        start_txn(1'b1, addr, data, 1'b0, 1'b0);
        while (!rsp.busy) @(posedge CLK);
        repeat (10) @(posedge CLK);
        req.wr    <= 1'b1;
        req.addr  <= other;
        req.wdata <= odata;
        @(posedge CLK);
        req.wr <= 1'b0;
        wait_ack();
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        RESET     <= 1'b1;
        req       <= '0;
        chk_data  <= 1'b0;
        exp_data  <= '0;
        exp_err   <= 1'b0;
        exp_falls <= 1;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET <= 1'b0;
        repeat (2) @(posedge CLK);

        // same word offset in all eight blocks
        word = 8'($urandom);
        for (int b = 0; b < 8; b++) begin
            write_byte({3'(b), word}, {5'($urandom), 3'(b)});   // low bits differ per block
            settle();
        end
        for (int b = 0; b < 8; b++) read_check({3'(b), word}, 1'b0);

        for (int i = 0; i < 4; i++) begin
            rnd_addr[i] = 11'($urandom);
            write_byte(rnd_addr[i], 8'($urandom));
            settle();
        end
        for (int i = 0; i < 4; i++) read_check(rnd_addr[i], 1'b0);

        // control byte refused while the device is still programming
        addr_a = 11'($urandom);
        write_byte(addr_a, 8'($urandom));
        read_check(addr_a, 1'b1);
        settle();
        read_check(addr_a, 1'b0);

        addr_b = {3'd0, word};
        addr_a = addr_b ^ 11'h5a5;
        write_with_busy_strobe(addr_a, 8'($urandom), addr_b, ~mirror[addr_b]);
        settle();
        read_check(addr_b, 1'b0);
        read_check(addr_a, 1'b0);

        repeat (4) @(posedge CLK);
        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
        if (data_errs + proto_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the transactions did not complete within %0d ns", WATCHDOG_NS);
        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
